// File: verilog.f
+incdir+rtl
rtl/float_arith_pkg.sv
rtl/float_op_issue.sv
rtl/float_adder.sv
rtl/float_multiplier.sv
rtl/float_divider.sv
rtl/float_result_stage.sv
rtl/float_arith_unit.sv
sim/float_arith_tb.sv

// File: Makefile
# Verilator build and run for the float arithmetic unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = float_arith_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove build outputs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: sim/float_arith_tb.sv
// Testbench for float_arith_unit: seeded random operations checked against a real-valued model
`include "float_arith_cfg.svh"

module float_arith_tb import float_arith_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Operation counts per test group
  localparam int RANDOM_OPS = 300;
  localparam int EDGE_OPS   = 12;
  localparam int BUSY_OPS   = 4;
  localparam int TOTAL_OPS  = RANDOM_OPS + EDGE_OPS + BUSY_OPS;
  // Worst case about 6 cycles per operation plus reset margin
  localparam int MAX_CYCLES = TOTAL_OPS * 6 + 50;
  localparam int EXP_W      = `FLOAT_EXP_MSB - `FLOAT_EXP_LSB + 1;
  // Moderate exponent band around 2^0
  localparam int BAND_LO    = 1003;
  localparam int BAND_SPAN  = 41;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  float_op_t                   opcode;
  logic [`FLOAT_DATA_SIZE-1:0] data_a;
  logic [`FLOAT_DATA_SIZE-1:0] data_b;
  logic                        busy;
  logic                        ready;
  logic [`FLOAT_DATA_SIZE-1:0] data_out;
  logic                        overflow;
  int                          cycle_count;

  float_arith_unit DUT (
    .CLK(CLK), .RST(RST), .start(start), .opcode(opcode),
    .data_a(data_a), .data_b(data_b), .busy(busy), .ready(ready),
    .data_out(data_out), .overflow(overflow)
  );

  ////////////////////////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) @(posedge CLK) cycle_count++;
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on timeout");
  end

  ////////////////////////////////////////////////////////////
  // Check and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [`FLOAT_DATA_SIZE-1:0] actual,
                             input logic [`FLOAT_DATA_SIZE-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s actual=%h expected=%h", name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on a failed check");
    end
  endtask

  // Exponent field all ones, inf or NaN
  function automatic logic exp_all_ones(input logic [`FLOAT_DATA_SIZE-1:0] x);
    return &x[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB];
  endfunction

  function automatic logic [`FLOAT_DATA_SIZE-1:0] model_result(
      input float_op_t op, input logic [`FLOAT_DATA_SIZE-1:0] a,
      input logic [`FLOAT_DATA_SIZE-1:0] b);
    real ra;
    real rb;
    real rr;
    ra = $bitstoreal(a);
    rb = $bitstoreal(b);
    case (op)
      OP_ADD:  rr = ra + rb;
      OP_SUB:  rr = ra - rb;
      OP_MUL:  rr = ra * rb;
      default: rr = ra / rb;
    endcase
    return $realtobits(rr);
  endfunction

  // Finite inputs, non-finite result
  function automatic logic model_overflow(input logic [`FLOAT_DATA_SIZE-1:0] a,
                                          input logic [`FLOAT_DATA_SIZE-1:0] b,
                                          input logic [`FLOAT_DATA_SIZE-1:0] r);
    return !exp_all_ones(a) && !exp_all_ones(b) && exp_all_ones(r);
  endfunction

  function automatic logic [`FLOAT_DATA_SIZE-1:0] inf_pattern(input logic sign);
    return {sign, {EXP_W{1'b1}}, 52'b0};
  endfunction

  // Random sign bit and mantissa around a given exponent field
  function automatic logic [`FLOAT_DATA_SIZE-1:0] build_float(input logic sign,
                                                              input logic [EXP_W-1:0] exp_field);
    logic [51:0] mant;
    mant = 52'({$urandom, $urandom});
    return {sign, exp_field, mant};
  endfunction

  function automatic logic [`FLOAT_DATA_SIZE-1:0] band_operand();
    return build_float(1'($urandom), EXP_W'(BAND_LO + ($urandom % BAND_SPAN)));
  endfunction

  ////////////////////////////////////////////////////////////
  // One operation, START to idle
  ////////////////////////////////////////////////////////////

  // Called right after a falling edge
  task automatic run_op(input float_op_t op, input logic [`FLOAT_DATA_SIZE-1:0] a,
                        input logic [`FLOAT_DATA_SIZE-1:0] b,
                        input logic [`FLOAT_DATA_SIZE-1:0] exp_data,
                        input logic exp_ovf, input logic extra_start);
    int cycles;
    start  = 1'b1;
    opcode = op;
    data_a = a;
    data_b = b;
    @(negedge CLK);
    cycles = 1;
    // Optional second request while busy, must be dropped
    start = extra_start;
    if (extra_start) begin
      opcode = float_op_t'(2'($urandom));
      data_a = band_operand();
      data_b = band_operand();
    end
    while (ready !== 1'b1) begin
      check_value("busy", 64'(busy), 64'd1);
      @(negedge CLK);
      cycles++;
      if (cycles >= `FLOAT_LATENCY) start = 1'b0;
    end
    check_value("ready latency", 64'(cycles), 64'(`FLOAT_LATENCY));
    check_value("busy", 64'(busy), 64'd1);
    check_value("data_out", data_out, exp_data);
    check_value("overflow", 64'(overflow), 64'(exp_ovf));
    @(negedge CLK);
    start = 1'b0;
    // Idle again, outputs held
    check_value("ready", 64'(ready), 64'd0);
    check_value("busy", 64'(busy), 64'd0);
    check_value("data_out", data_out, exp_data);
    check_value("overflow", 64'(overflow), 64'(exp_ovf));
    if (extra_start) begin
      // No second ready from the dropped request
      repeat (`FLOAT_LATENCY) begin
        @(negedge CLK);
        check_value("ready", 64'(ready), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [`FLOAT_DATA_SIZE-1:0] a;
    logic [`FLOAT_DATA_SIZE-1:0] b;
    logic [`FLOAT_DATA_SIZE-1:0] r;
    logic                        sign;
    float_op_t                   op;
    void'($urandom(32'h10a0));
    RST    = 1'b1;
    start  = 1'b0;
    opcode = OP_ADD;
    data_a = '0;
    data_b = '0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;

    // Reset values, then a few idle cycles
    repeat (3) begin
      check_value("ready", 64'(ready), 64'd0);
      check_value("busy", 64'(busy), 64'd0);
      check_value("data_out", data_out, 64'd0);
      check_value("overflow", 64'(overflow), 64'd0);
      @(negedge CLK);
    end

    // Random operands, opcodes in rotation
    for (int i = 0; i < RANDOM_OPS; i++) begin
      op = float_op_t'(2'(i));
      a  = band_operand();
      b  = band_operand();
      r  = model_result(op, a, b);
      run_op(op, a, b, r, model_overflow(a, b, r), 1'b0);
    end

    // Multiply near the top of the range
    for (int i = 0; i < 4; i++) begin
      a = build_float(1'($urandom), EXP_W'(11'h7f0 + ($urandom % 14)));
      b = build_float(1'($urandom), EXP_W'(11'h7f0 + ($urandom % 14)));
      run_op(OP_MUL, a, b, inf_pattern(a[63] ^ b[63]), 1'b1, 1'b0);
    end

    // Add with equal signs, subtract with opposite signs
    for (int i = 0; i < 4; i++) begin
      sign = 1'(i);
      a    = build_float(sign, 11'h7fe);
      if (i < 2) begin
        b = build_float(sign, 11'h7fe);
        run_op(OP_ADD, a, b, inf_pattern(sign), 1'b1, 1'b0);
      end else begin
        b = build_float(~sign, 11'h7fe);
        run_op(OP_SUB, a, b, inf_pattern(sign), 1'b1, 1'b0);
      end
    end

    // Finite dividend over plus and minus zero
    for (int i = 0; i < 4; i++) begin
      a = band_operand();
      b = {1'(i), 63'b0};
      run_op(OP_DIV, a, b, inf_pattern(a[63] ^ b[63]), 1'b1, 1'b0);
    end

    // Extra START while busy, one per opcode
    for (int i = 0; i < BUSY_OPS; i++) begin
      op = float_op_t'(2'(i));
      a  = band_operand();
      b  = band_operand();
      r  = model_result(op, a, b);
      run_op(op, a, b, r, model_overflow(a, b, r), 1'b1);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: rtl/float_arith_unit.sv
// Top level of the scalar float unit: issue stage, three arithmetic units, result stage
`include "float_arith_cfg.svh"

module float_arith_unit import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  float_op_t                   opcode,
  input  logic [`FLOAT_DATA_SIZE-1:0] data_a,
  input  logic [`FLOAT_DATA_SIZE-1:0] data_b,
  output logic                        busy,
  output logic                        ready,
  output logic [`FLOAT_DATA_SIZE-1:0] data_out,
  output logic                        overflow
);

  // Shared operands and launch pulses
  logic [`FLOAT_DATA_SIZE-1:0] operand_a;
  logic [`FLOAT_DATA_SIZE-1:0] operand_b;
  logic                        add_start;
  logic                        subtract;
  logic                        mul_start;
  logic                        div_start;

  // Unit outputs
  logic                        add_done;
  logic [`FLOAT_DATA_SIZE-1:0] add_result;
  logic                        add_overflow;
  logic                        mul_done;
  logic [`FLOAT_DATA_SIZE-1:0] mul_result;
  logic                        mul_overflow;
  logic                        div_done;
  logic [`FLOAT_DATA_SIZE-1:0] div_result;
  logic                        div_overflow;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  float_op_issue u_issue (
    .CLK(CLK), .RST(RST), .start(start), .opcode(opcode),
    .data_a(data_a), .data_b(data_b), .ready(ready), .busy(busy),
    .operand_a(operand_a), .operand_b(operand_b), .add_start(add_start),
    .subtract(subtract), .mul_start(mul_start), .div_start(div_start)
  );

  ////////////////////////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////////////////////////

  float_adder u_adder (
    .CLK(CLK), .RST(RST), .start(add_start), .subtract(subtract),
    .operand_a(operand_a), .operand_b(operand_b),
    .done(add_done), .result(add_result), .overflow(add_overflow)
  );

  float_multiplier u_multiplier (
    .CLK(CLK), .RST(RST), .start(mul_start),
    .operand_a(operand_a), .operand_b(operand_b),
    .done(mul_done), .result(mul_result), .overflow(mul_overflow)
  );

  float_divider u_divider (
    .CLK(CLK), .RST(RST), .start(div_start),
    .operand_a(operand_a), .operand_b(operand_b),
    .done(div_done), .result(div_result), .overflow(div_overflow)
  );

  // Output side, ready also closes the issue window
  float_result_stage u_result (
    .CLK(CLK), .RST(RST),
    .add_done(add_done), .add_result(add_result), .add_overflow(add_overflow),
    .mul_done(mul_done), .mul_result(mul_result), .mul_overflow(mul_overflow),
    .div_done(div_done), .div_result(div_result), .div_overflow(div_overflow),
    .ready(ready), .data_out(data_out), .overflow(overflow)
  );

endmodule

// File: rtl/float_result_stage.sv
// Result stage: captures the finishing unit's output and pulses READY for one cycle
`include "float_arith_cfg.svh"

module float_result_stage import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        add_done,
  input  logic [`FLOAT_DATA_SIZE-1:0] add_result,
  input  logic                        add_overflow,
  input  logic                        mul_done,
  input  logic [`FLOAT_DATA_SIZE-1:0] mul_result,
  input  logic                        mul_overflow,
  input  logic                        div_done,
  input  logic [`FLOAT_DATA_SIZE-1:0] div_result,
  input  logic                        div_overflow,
  output logic                        ready,
  output logic [`FLOAT_DATA_SIZE-1:0] data_out,
  output logic                        overflow
);

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready    <= 1'b0;
      data_out <= '0;
      overflow <= 1'b0;
    end else begin
      // One-cycle strobe per finished operation
      ready <= add_done | mul_done | div_done;
      // Select the unit that finished, else hold
      if (add_done) begin
        data_out <= add_result;
        overflow <= add_overflow;
      end else if (mul_done) begin
        data_out <= mul_result;
        overflow <= mul_overflow;
      end else if (div_done) begin
        data_out <= div_result;
        overflow <= div_overflow;
      end
    end
  end

  // Single operation in flight, so units never finish together
  assert property (@(posedge CLK) disable iff (RST)
    $onehot0({add_done, mul_done, div_done}));

endmodule

// File: rtl/float_divider.sv
// Divide unit: two-state controller over real arithmetic, flags finite-to-infinite results
`include "float_arith_cfg.svh"

module float_divider import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_a,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_b,
  output logic                        done,
  output logic [`FLOAT_DATA_SIZE-1:0] result,
  output logic                        overflow
);

  unit_state_t                 state;
  real                         dividend;
  real                         divisor;
  logic                        inputs_finite;
  logic [`FLOAT_DATA_SIZE-1:0] quot_bits;

  // Quotient back in bit form
  // Zero divisor gives signed infinity, or NaN for 0/0
  assign quot_bits = $realtobits(dividend / divisor);

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        // Step 0, wait for launch
        ST_IDLE:    if (start) state <= ST_COMPUTE;
        // Step 1, quotient out
        ST_COMPUTE: begin
          done  <= 1'b1;
          state <= ST_IDLE;
        end
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // Operand conversion and result
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      dividend      <= $bitstoreal(operand_a);
      divisor       <= $bitstoreal(operand_b);
      inputs_finite <= ~&operand_a[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB] &&
                       ~&operand_b[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB];
    end
    if (state == ST_COMPUTE) begin
      result   <= quot_bits;
      // Division by zero lands here too
      overflow <= inputs_finite && (&quot_bits[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB]);
    end
  end

  // Issue stage must not relaunch a running unit
  assert property (@(posedge CLK) disable iff (RST) start |-> state == ST_IDLE);

endmodule

// File: rtl/float_multiplier.sv
// Multiply unit: two-state controller over real arithmetic with overflow detection
`include "float_arith_cfg.svh"

module float_multiplier import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_a,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_b,
  output logic                        done,
  output logic [`FLOAT_DATA_SIZE-1:0] result,
  output logic                        overflow
);

  unit_state_t                 state;
  real                         op_a_real;
  real                         op_b_real;
  logic                        inputs_finite;
  logic [`FLOAT_DATA_SIZE-1:0] prod_bits;

  // Product back in bit form
  assign prod_bits = $realtobits(op_a_real * op_b_real);

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE:    if (start) state <= ST_COMPUTE;
        ST_COMPUTE: begin
          done  <= 1'b1;
          state <= ST_IDLE;
        end
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // Operand conversion and result
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      op_a_real     <= $bitstoreal(operand_a);
      op_b_real     <= $bitstoreal(operand_b);
      inputs_finite <= ~&operand_a[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB] &&
                       ~&operand_b[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB];
    end
    if (state == ST_COMPUTE) begin
      result   <= prod_bits;
      // Finite inputs, non-finite product
      overflow <= inputs_finite && (&prod_bits[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB]);
    end
  end

  // Issue stage must not relaunch a running unit
  assert property (@(posedge CLK) disable iff (RST) start |-> state == ST_IDLE);

endmodule

// File: rtl/float_adder.sv
// Add/subtract unit: two-state controller over real arithmetic with overflow detection
`include "float_arith_cfg.svh"

module float_adder import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic                        subtract,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_a,
  input  logic [`FLOAT_DATA_SIZE-1:0] operand_b,
  output logic                        done,
  output logic [`FLOAT_DATA_SIZE-1:0] result,
  output logic                        overflow
);

  unit_state_t                 state;
  real                         op_a_real;
  real                         op_b_real;
  logic                        sub_q;
  logic                        inputs_finite;
  logic [`FLOAT_DATA_SIZE-1:0] sum_bits;

  // Sum or difference back in bit form
  always_comb begin
    if (sub_q) sum_bits = $realtobits(op_a_real - op_b_real);
    else       sum_bits = $realtobits(op_a_real + op_b_real);
  end

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE:    if (start) state <= ST_COMPUTE;
        ST_COMPUTE: begin
          done  <= 1'b1;
          state <= ST_IDLE;
        end
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // Operand conversion and result
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      op_a_real     <= $bitstoreal(operand_a);
      op_b_real     <= $bitstoreal(operand_b);
      sub_q         <= subtract;
      // Exponent all ones means inf or NaN
      inputs_finite <= ~&operand_a[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB] &&
                       ~&operand_b[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB];
    end
    if (state == ST_COMPUTE) begin
      result   <= sum_bits;
      overflow <= inputs_finite && (&sum_bits[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB]);
    end
  end

  // Issue stage must not relaunch a running unit
  assert property (@(posedge CLK) disable iff (RST) start |-> state == ST_IDLE);

endmodule

// File: rtl/float_op_issue.sv
// Issue stage that latches operands on START, holds BUSY and fires one unit start pulse
`include "float_arith_cfg.svh"

module float_op_issue import float_arith_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  float_op_t                   opcode,
  input  logic [`FLOAT_DATA_SIZE-1:0] data_a,
  input  logic [`FLOAT_DATA_SIZE-1:0] data_b,
  input  logic                        ready,
  output logic                        busy,
  output logic [`FLOAT_DATA_SIZE-1:0] operand_a,
  output logic [`FLOAT_DATA_SIZE-1:0] operand_b,
  output logic                        add_start,
  output logic                        subtract,
  output logic                        mul_start,
  output logic                        div_start
);

  issue_state_t state;
  logic         accept;

  // New request only taken when idle
  assign accept = start && (state == IS_IDLE);
  assign busy   = (state == IS_BUSY);

  ////////////////////////////////////////////////////////////
  // Control FSM and start pulses
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IS_IDLE;
      add_start <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      // Pulses last a single cycle
      add_start <= accept && ((opcode == OP_ADD) || (opcode == OP_SUB));
      mul_start <= accept && (opcode == OP_MUL);
      div_start <= accept && (opcode == OP_DIV);
      case (state)
        IS_IDLE: if (accept) state <= IS_BUSY;
        // Result stage closes the operation
        IS_BUSY: if (ready) state <= IS_IDLE;
        default: state <= IS_IDLE;
      endcase
    end
  end

  // Operand capture shared by all units
  always_ff @(posedge CLK) begin
    if (accept) begin
      operand_a <= data_a;
      operand_b <= data_b;
      subtract  <= (opcode == OP_SUB);
    end
  end

  // Result stage answers only an operation in flight
  assert property (@(posedge CLK) disable iff (RST) ready |-> busy);

endmodule

// File: rtl/float_arith_pkg.sv
// Opcode and FSM state types shared by every block of the float arithmetic unit
package float_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_DIV = 2'd3
  } float_op_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  // Controller inside each arithmetic unit
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_COMPUTE = 1'b1
  } unit_state_t;

  // Issue stage, one operation in flight
  typedef enum logic {
    IS_IDLE = 1'b0,
    IS_BUSY = 1'b1
  } issue_state_t;

endpackage

// File: rtl/float_arith_cfg.svh
// Double-precision format limits for the float arithmetic unit, included by RTL and testbench
`ifndef FLOAT_ARITH_CFG_SVH
`define FLOAT_ARITH_CFG_SVH

////////////////////////////////////////////////////////////
// IEEE-754 double layout
////////////////////////////////////////////////////////////

// Operand and result width
`define FLOAT_DATA_SIZE 64

// Exponent field bounds
`define FLOAT_EXP_MSB 62
`define FLOAT_EXP_LSB 52

// START sampled to READY high, in clock cycles
`define FLOAT_LATENCY 4

`endif
